//--- logic/decode_unit.sv
`default_nettype none

module decode_unit (
    input  isa_pkg::fd_t      fd,
    output isa_pkg::reg_idx_t rd_a_idx,
    output isa_pkg::reg_idx_t rd_b_idx,
    output isa_pkg::reg_idx_t rd_c_idx,
    input  isa_pkg::word_t    rd_a,
    input  isa_pkg::word_t    rd_b,
    input  isa_pkg::word_t    rd_c,
    output isa_pkg::de_t      de
);

    isa_pkg::opcode_e opcode;
    isa_pkg::word_t   imm4;
    isa_pkg::word_t   imm8;

    assign opcode   = isa_pkg::opcode_e'(fd.instr[isa_pkg::OPC_LSB +: 4]);
    assign rd_a_idx = fd.instr[isa_pkg::RS_LSB +: 4];
    assign rd_b_idx = fd.instr[isa_pkg::RT_LSB +: 4];
    assign rd_c_idx = fd.instr[isa_pkg::RD_LSB +: 4];

    assign imm4 = {{(16 - isa_pkg::IMM4_W){fd.instr[isa_pkg::IMM4_W-1]}},
                   fd.instr[isa_pkg::IMM4_W-1:0]};
    assign imm8 = {{(16 - isa_pkg::IMM8_W){1'b0}}, fd.instr[isa_pkg::IMM8_W-1:0]};

    always_comb begin
        de       = '0;
        de.valid = fd.valid;
        de.op    = opcode;
        de.pc    = fd.pc;
        de.dest  = rd_c_idx;
        de.imm   = imm4;
        de.a     = rd_a;
        de.b     = rd_b;
        de.c     = rd_c;
        if (fd.valid) begin // Bubbles carry no control.
            case (opcode)
                isa_pkg::ADD, isa_pkg::SUB, isa_pkg::AND,
                isa_pkg::OR, isa_pkg::XOR, isa_pkg::SHL: begin
                    de.reg_write = 1'b1;
                end
                isa_pkg::ADDI: begin
                    de.reg_write   = 1'b1;
                    de.alu_src_imm = 1'b1;
                end
                isa_pkg::LI: begin
                    de.reg_write   = 1'b1;
                    de.alu_src_imm = 1'b1;
                    de.imm         = imm8;
                end
                isa_pkg::LD: begin
                    de.reg_write   = 1'b1;
                    de.mem_to_reg  = 1'b1;
                    de.alu_src_imm = 1'b1;
                end
                isa_pkg::ST: begin
                    de.mem_write   = 1'b1;
                    de.alu_src_imm = 1'b1;
                end
                isa_pkg::BEQ: de.is_branch = 1'b1;
                isa_pkg::BNE: begin
                    de.is_branch = 1'b1;
                    de.branch_ne = 1'b1;
                end
                isa_pkg::HALT: de.halt = 1'b1;
                default: ; // No-op.
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/execute_unit.sv
`default_nettype none

module execute_unit #(
    parameter int DMEM_DEPTH = 256
) (
    input  wire                          clock,
    input  wire                          rst,
    input  isa_pkg::de_t                 de,
    output logic                         wr_en,
    output isa_pkg::reg_idx_t            wr_idx,
    output isa_pkg::word_t               wr_data,
    output logic                         branch_taken,
    output isa_pkg::word_t               branch_target,
    output logic                         halt_seen,
    input  wire [$clog2(DMEM_DEPTH)-1:0] host_dmem_addr,
    output isa_pkg::word_t               host_dmem_data
);

    localparam int DMEM_AW = $clog2(DMEM_DEPTH);

    isa_pkg::word_t dmem [DMEM_DEPTH];
    isa_pkg::word_t operand2;
    isa_pkg::word_t sum;
    isa_pkg::word_t alu_result;
    isa_pkg::word_t load_data;
    logic [DMEM_AW-1:0] mem_addr;
    logic           equal;

    assign operand2 = de.alu_src_imm ? de.imm : de.b;
    assign sum      = de.a + operand2; // Also the LD/ST address.
    assign mem_addr = sum[DMEM_AW-1:0];

    always_comb begin
        case (de.op)
            isa_pkg::SUB: alu_result = de.a - de.b;
            isa_pkg::AND: alu_result = de.a & de.b;
            isa_pkg::OR:  alu_result = de.a | de.b;
            isa_pkg::XOR: alu_result = de.a ^ de.b;
            isa_pkg::SHL: alu_result = de.a << de.b[3:0];
            isa_pkg::LI:  alu_result = operand2;
            default:      alu_result = sum;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst && de.valid && de.mem_write) begin
            dmem[mem_addr] <= de.c;
        end
    end

    assign load_data      = dmem[mem_addr];
    assign host_dmem_data = dmem[host_dmem_addr];

    assign wr_en   = de.valid && de.reg_write;
    assign wr_idx  = de.dest;
    assign wr_data = de.mem_to_reg ? load_data : alu_result;

    // Branches compare rd with rs.
    assign equal         = (de.c == de.a);
    assign branch_taken  = de.valid && de.is_branch && (de.branch_ne ? !equal : equal);
    assign branch_target = de.pc + 16'd1 + de.imm;
    assign halt_seen     = de.valid && de.halt;

endmodule

`default_nettype wire

//--- logic/fetch_unit.sv
`default_nettype none

module fetch_unit #(
    parameter int IMEM_DEPTH = 256
) (
    input  wire                          clock,
    input  wire                          rst,
    input  wire                          advance,
    input  wire                          restart,
    input  wire                          branch_taken,
    input  isa_pkg::word_t               branch_target,
    input  wire                          imem_we,
    input  wire [$clog2(IMEM_DEPTH)-1:0] imem_addr,
    input  isa_pkg::word_t               imem_wdata,
    output isa_pkg::fd_t                 fd
);

    localparam int IMEM_AW = $clog2(IMEM_DEPTH);

    isa_pkg::word_t pc;
    isa_pkg::word_t imem [IMEM_DEPTH];

    always_ff @(posedge clock) begin
        if (rst || restart) begin
            pc <= '0;
        end else if (branch_taken) begin
            pc <= branch_target; // Redirect from execute.
        end else if (advance) begin
            pc <= pc + 16'd1;
        end
    end

    // Host loads the program here.
    always_ff @(posedge clock) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    always_comb begin
        fd.valid = (pc < IMEM_DEPTH); // Running off the end gives bubbles.
        fd.pc    = pc;
        fd.instr = imem[pc[IMEM_AW-1:0]];
    end

endmodule

`default_nettype wire

//--- logic/host_pkg.sv
`default_nettype none

package host_pkg;

    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 12;

    // Byte offsets.
    localparam logic [ADDR_WIDTH-1:0] CTRL_ADDR   = 12'h000;
    localparam logic [ADDR_WIDTH-1:0] STATUS_ADDR = 12'h004;
    localparam logic [ADDR_WIDTH-1:0] REG_BASE    = 12'h100;
    localparam logic [ADDR_WIDTH-1:0] IMEM_BASE   = 12'h400;
    localparam logic [ADDR_WIDTH-1:0] DMEM_BASE   = 12'h800;

    // Field positions.
    localparam int CTRL_START_BIT  = 0;
    localparam int STATUS_RUN_BIT  = 0;
    localparam int STATUS_HALT_BIT = 1;
    localparam int STATUS_PC_LSB   = 16;

endpackage

`default_nettype wire

//--- logic/host_port.sv
`default_nettype none

module host_port #(
    parameter int IMEM_DEPTH = 256,
    parameter int DMEM_DEPTH = 256
) (
    input  wire                                clock,
    input  wire                                rst,
    input  wire                                psel,
    input  wire                                penable,
    input  wire                                pwrite,
    input  wire [host_pkg::ADDR_WIDTH-1:0]     paddr,
    input  wire [host_pkg::DATA_WIDTH-1:0]     pwdata,
    output logic [host_pkg::DATA_WIDTH-1:0]    prdata,
    output logic                               pready,
    output logic                               pslverr,
    output logic                               imem_we,
    output logic [$clog2(IMEM_DEPTH)-1:0]      imem_addr,
    output isa_pkg::word_t                     imem_wdata,
    output isa_pkg::reg_idx_t                  host_reg_idx,
    input  isa_pkg::word_t                     host_reg_data,
    output logic [$clog2(DMEM_DEPTH)-1:0]      host_dmem_addr,
    input  isa_pkg::word_t                     host_dmem_data,
    output logic                               start,
    input  wire                                running,
    input  wire                                halted,
    input  isa_pkg::word_t                     pc
);

    localparam int IMEM_AW = $clog2(IMEM_DEPTH);
    localparam int DMEM_AW = $clog2(DMEM_DEPTH);

    logic [7:0] word_idx;
    logic is_ctrl, is_status, is_reg, is_imem, is_dmem, mapped, err, err_q, access;

    assign word_idx  = paddr[9:2];
    assign is_ctrl   = (paddr == host_pkg::CTRL_ADDR);
    assign is_status = (paddr == host_pkg::STATUS_ADDR);
    assign is_reg    = (paddr[11:6] == host_pkg::REG_BASE[11:6]) && (paddr[1:0] == 2'b00);
    assign is_imem   = (paddr[11:10] == host_pkg::IMEM_BASE[11:10]) && (paddr[1:0] == 2'b00)
                       && (word_idx < IMEM_DEPTH);
    assign is_dmem   = (paddr[11:10] == host_pkg::DMEM_BASE[11:10]) && (paddr[1:0] == 2'b00)
                       && (word_idx < DMEM_DEPTH);
    assign mapped    = is_ctrl || is_status || is_reg || is_imem || is_dmem;

    // IMEM is write only; status, registers and DMEM are read only.
    assign err = !mapped
              || (pwrite && (is_status || is_reg || is_dmem))
              || (!pwrite && is_imem)
              || (pwrite && is_imem && running);

    // Error is decided in the setup phase and reported in the access phase.
    always_ff @(posedge clock) begin
        if (rst) begin
            err_q <= 1'b0;
        end else if (psel && !penable) begin
            err_q <= err;
        end
    end

    assign access  = psel && penable;
    assign pready  = 1'b1;
    assign pslverr = access && err_q;

    assign imem_we        = access && pwrite && is_imem && !running;
    assign imem_addr      = paddr[IMEM_AW+1:2];
    assign imem_wdata     = pwdata[15:0];
    assign host_reg_idx   = paddr[5:2];
    assign host_dmem_addr = paddr[DMEM_AW+1:2];
    assign start          = access && pwrite && is_ctrl && pwdata[host_pkg::CTRL_START_BIT];

    always_comb begin
        prdata = '0;
        if (is_status) begin
            prdata[host_pkg::STATUS_RUN_BIT]        = running;
            prdata[host_pkg::STATUS_HALT_BIT]       = halted;
            prdata[host_pkg::STATUS_PC_LSB +: 16]   = pc;
        end else if (is_reg) begin
            prdata[15:0] = host_reg_data;
        end else if (is_dmem) begin
            prdata[15:0] = host_dmem_data;
        end
    end

endmodule

`default_nettype wire

//--- logic/isa_pkg.sv
`default_nettype none

package isa_pkg;

    typedef logic [15:0] word_t;
    typedef logic [3:0] reg_idx_t;

    // Remaining codes 13..15 execute as no-ops.
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SHL  = 4'd5,
        ADDI = 4'd6,
        LI   = 4'd7,
        LD   = 4'd8,
        ST   = 4'd9,
        BEQ  = 4'd10,
        BNE  = 4'd11,
        HALT = 4'd12
    } opcode_e;

    // Field positions of an instruction word.
    localparam int OPC_LSB = 12;
    localparam int RD_LSB  = 8;
    localparam int RS_LSB  = 4;
    localparam int RT_LSB  = 0;
    localparam int IMM4_W  = 4; // Sign-extended.
    localparam int IMM8_W  = 8; // Zero-extended, LI only.

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } fd_t;

    typedef struct packed {
        logic     valid;
        opcode_e  op;
        word_t    pc;
        reg_idx_t dest;
        word_t    imm;
        word_t    a; // rs
        word_t    b; // rt
        word_t    c; // rd
        logic     reg_write;
        logic     mem_write;
        logic     mem_to_reg;
        logic     alu_src_imm;
        logic     is_branch;
        logic     branch_ne;
        logic     halt;
    } de_t;

endpackage

`default_nettype wire

//--- logic/pipe16_top.sv
`default_nettype none

module pipe16_top #(
    parameter int IMEM_DEPTH = 256,
    parameter int DMEM_DEPTH = 256
) (
    input  wire                             clock,
    input  wire                             rst,
    input  wire                             psel,
    input  wire                             penable,
    input  wire                             pwrite,
    input  wire [host_pkg::ADDR_WIDTH-1:0]  paddr,
    input  wire [host_pkg::DATA_WIDTH-1:0]  pwdata,
    output logic [host_pkg::DATA_WIDTH-1:0] prdata,
    output logic                            pready,
    output logic                            pslverr
);

    isa_pkg::fd_t      fd_d, fd_q;
    isa_pkg::de_t      de_d, de_q;
    isa_pkg::reg_idx_t rd_a_idx, rd_b_idx, rd_c_idx, wr_idx, host_reg_idx;
    isa_pkg::word_t    rd_a, rd_b, rd_c, wr_data, host_reg_data;
    isa_pkg::word_t    branch_target, imem_wdata, host_dmem_data;
    logic [$clog2(IMEM_DEPTH)-1:0] imem_addr;
    logic [$clog2(DMEM_DEPTH)-1:0] host_dmem_addr;
    logic wr_en, branch_taken, halt_seen, imem_we, start;
    logic restart, advance, flush_fd, flush_de, running, halted;

    fetch_unit #(.IMEM_DEPTH(IMEM_DEPTH)) fetch_unit_i (
        .clock, .rst, .advance, .restart, .branch_taken, .branch_target,
        .imem_we, .imem_addr, .imem_wdata, .fd(fd_d)
    );

    stage_reg #(.payload_t(isa_pkg::fd_t)) fd_reg_i (
        .clock, .rst, .enable(advance), .flush(flush_fd), .d(fd_d), .q(fd_q)
    );

    decode_unit decode_unit_i (
        .fd(fd_q), .rd_a_idx, .rd_b_idx, .rd_c_idx, .rd_a, .rd_b, .rd_c, .de(de_d)
    );

    register_file register_file_i (
        .clock, .rst, .rd_a_idx, .rd_b_idx, .rd_c_idx, .rd_a, .rd_b, .rd_c,
        .wr_en, .wr_idx, .wr_data, .host_reg_idx, .host_reg_data
    );

    stage_reg #(.payload_t(isa_pkg::de_t)) de_reg_i (
        .clock, .rst, .enable(advance), .flush(flush_de), .d(de_d), .q(de_q)
    );

    execute_unit #(.DMEM_DEPTH(DMEM_DEPTH)) execute_unit_i (
        .clock, .rst, .de(de_q), .wr_en, .wr_idx, .wr_data, .branch_taken,
        .branch_target, .halt_seen, .host_dmem_addr, .host_dmem_data
    );

    pipeline_control pipeline_control_i (
        .clock, .rst, .start, .branch_taken, .halt_seen, .restart, .advance,
        .flush_fd, .flush_de, .running, .halted
    );

    // STATUS reports the fetch pc, which holds once halted.
    host_port #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) host_port_i (
        .clock, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
        .pslverr, .imem_we, .imem_addr, .imem_wdata, .host_reg_idx, .host_reg_data,
        .host_dmem_addr, .host_dmem_data, .start, .running, .halted, .pc(fd_d.pc)
    );

endmodule

`default_nettype wire

//--- logic/pipeline_control.sv
`default_nettype none

module pipeline_control (
    input  wire  clock,
    input  wire  rst,
    input  wire  start,
    input  wire  branch_taken,
    input  wire  halt_seen,
    output logic restart,
    output logic advance,
    output logic flush_fd,
    output logic flush_de,
    output logic running,
    output logic halted
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        HALTED
    } state_e;

    state_e state;

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= IDLE;
        end else if (start) begin
            state <= RUN; // Restart is allowed from any state.
        end else if (state == RUN && halt_seen) begin
            state <= HALTED;
        end
    end

    assign running = (state == RUN);
    assign halted  = (state == HALTED);
    assign restart = start;

    // HALT freezes the stages on its own edge, so nothing younger runs.
    assign advance = running && !halt_seen;

    // Taken branch squashes the two younger slots.
    assign flush_fd = start || (running && branch_taken);
    assign flush_de = start || (running && branch_taken);

endmodule

`default_nettype wire

//--- logic/register_file.sv
`default_nettype none

module register_file (
    input  wire               clock,
    input  wire               rst,
    input  isa_pkg::reg_idx_t rd_a_idx,
    input  isa_pkg::reg_idx_t rd_b_idx,
    input  isa_pkg::reg_idx_t rd_c_idx,
    output isa_pkg::word_t    rd_a,
    output isa_pkg::word_t    rd_b,
    output isa_pkg::word_t    rd_c,
    input  wire               wr_en,
    input  isa_pkg::reg_idx_t wr_idx,
    input  isa_pkg::word_t    wr_data,
    input  isa_pkg::reg_idx_t host_reg_idx,
    output isa_pkg::word_t    host_reg_data
);

    isa_pkg::word_t regs [16];
    logic           wr_live;

    assign wr_live = wr_en && (wr_idx != '0); // r0 stays zero.

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Same-cycle write passes through, so decode never sees stale data.
    assign rd_a = (wr_live && wr_idx == rd_a_idx) ? wr_data : regs[rd_a_idx];
    assign rd_b = (wr_live && wr_idx == rd_b_idx) ? wr_data : regs[rd_b_idx];
    assign rd_c = (wr_live && wr_idx == rd_c_idx) ? wr_data : regs[rd_c_idx];

    assign host_reg_data = regs[host_reg_idx];

endmodule

`default_nettype wire

//--- logic/stage_reg.sv
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  wire      clock,
    input  wire      rst,
    input  wire      enable,
    input  wire      flush,
    input  payload_t d,
    output payload_t q
);

    // Flush wins over enable; a cleared payload is a bubble.
    always_ff @(posedge clock) begin
        if (rst || flush) begin
            q <= '0;
        end else if (enable) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

//--- pipe16.f
+incdir+tests
logic/isa_pkg.sv
logic/host_pkg.sv
logic/stage_reg.sv
logic/fetch_unit.sv
logic/register_file.sv
logic/decode_unit.sv
logic/execute_unit.sv
logic/pipeline_control.sv
logic/host_port.sv
logic/pipe16_top.sv
tests/pipe16_tb.sv

//--- tests/pipe16_tests.svh
    // imm4 travels in the rt field.
    function automatic isa_pkg::word_t instr(input isa_pkg::opcode_e op, input int rd,
                                             input int rs, input int rt);
        return {op, rd[3:0], rs[3:0], rt[3:0]};
    endfunction

    function automatic isa_pkg::word_t load_imm(input int rd, input int imm);
        return {isa_pkg::LI, rd[3:0], imm[7:0]};
    endfunction

    // Reference model: one instruction at a time, up to HALT.
    task automatic run_model();
        isa_pkg::word_t pc;
        isa_pkg::word_t ir;
        isa_pkg::word_t a;
        isa_pkg::word_t b;
        isa_pkg::word_t c;
        isa_pkg::word_t imm;
        isa_pkg::word_t result;
        logic           wr;
        pc = '0;
        repeat (1000) begin
            ir  = prog[pc];
            a   = model_regs[ir[7:4]];
            b   = model_regs[ir[3:0]];
            c   = model_regs[ir[11:8]];
            imm = {{12{ir[3]}}, ir[3:0]};
            wr  = 1'b1;
            pc  = pc + 16'd1;
            case (ir[15:12])
                isa_pkg::ADD:  result = a + b;
                isa_pkg::SUB:  result = a - b;
                isa_pkg::AND:  result = a & b;
                isa_pkg::OR:   result = a | b;
                isa_pkg::XOR:  result = a ^ b;
                isa_pkg::SHL:  result = a << b[3:0];
                isa_pkg::ADDI: result = a + imm;
                isa_pkg::LI:   result = {8'h00, ir[7:0]};
                isa_pkg::LD:   result = model_dmem[(a + imm) % DMEM_DEPTH];
                isa_pkg::HALT: begin
                    model_halt_pc = pc - 16'd1;
                    return;
                end
                default: begin
                    wr = 1'b0;
                    if (ir[15:12] == isa_pkg::ST) model_dmem[(a + imm) % DMEM_DEPTH] = c;
                    if (ir[15:12] == isa_pkg::BEQ && c == a) pc = pc + imm;
                    if (ir[15:12] == isa_pkg::BNE && c != a) pc = pc + imm;
                end
            endcase
            if (wr && ir[11:8] != 4'd0) model_regs[ir[11:8]] = result;
        end
        $display("The reference model found no HALT within 1000 instructions.");
        errors++;
        test_errors++;
    endtask

    task automatic load_program();
        logic err;
        foreach (prog[i]) begin
            apb_write(host_pkg::IMEM_BASE + 12'(4 * i), 32'(prog[i]), err);
            compare_error(err, 1'b0, $sformatf("IMEM write %0d", i));
        end
    endtask

    task automatic start_run();
        logic err;
        apb_write(host_pkg::CTRL_ADDR, 32'h1, err);
        compare_error(err, 1'b0, "CTRL write");
    endtask

    task automatic wait_halt();
        logic [31:0] status;
        logic        err;
        int          polls;
        status = '0;
        for (polls = 0; polls < POLL_LIMIT && !status[host_pkg::STATUS_HALT_BIT]; polls++) begin
            apb_read(host_pkg::STATUS_ADDR, status, err);
        end
        if (!status[host_pkg::STATUS_HALT_BIT]) begin
            $display("The program did not halt within %0d status polls.", POLL_LIMIT);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_registers();
        logic [31:0] data;
        logic        err;
        for (int r = 0; r < 16; r++) begin
            apb_read(host_pkg::REG_BASE + 12'(4 * r), data, err);
            compare_word(data[15:0], model_regs[r], $sformatf("r%0d", r));
        end
    endtask

    // Fetch runs two slots ahead of execute, so the frozen pc is HALT's plus two.
    task automatic check_halt_status(input string what);
        logic [31:0] status;
        logic        err;
        apb_read(host_pkg::STATUS_ADDR, status, err);
        compare_status(status[host_pkg::STATUS_RUN_BIT], status[host_pkg::STATUS_HALT_BIT],
                       status[host_pkg::STATUS_PC_LSB +: 16], 1'b0, 1'b1,
                       model_halt_pc + 16'd2, what);
    endtask

    task automatic run_program();
        load_program();
        run_model();
        start_run();
        wait_halt();
        check_registers();
        check_halt_status("status after HALT");
    endtask

    task automatic alu_test();
        prog = {load_imm(1, $random(seed)), load_imm(2, $random(seed)),
                load_imm(3, $random(seed)), load_imm(4, $random(seed)),
                instr(isa_pkg::ADD, 5, 1, 2), instr(isa_pkg::SUB, 6, 1, 2),
                instr(isa_pkg::AND, 7, 3, 4), instr(isa_pkg::OR, 8, 3, 4),
                instr(isa_pkg::XOR, 9, 1, 4), instr(isa_pkg::SHL, 10, 2, 3),
                instr(isa_pkg::ADDI, 11, 5, -3), instr(isa_pkg::ADDI, 12, 6, 7),
                instr(isa_pkg::ADD, 0, 1, 2), // r0 must ignore this.
                instr(isa_pkg::HALT, 0, 0, 0)};
        run_program();
    endtask

    task automatic chain_test();
        prog = {load_imm(1, $random(seed)), instr(isa_pkg::ADDI, 1, 1, 3),
                instr(isa_pkg::ADD, 2, 1, 1), instr(isa_pkg::SUB, 3, 2, 1),
                instr(isa_pkg::SHL, 4, 3, 1), instr(isa_pkg::XOR, 5, 4, 3),
                instr(isa_pkg::OR, 6, 5, 2), instr(isa_pkg::AND, 7, 6, 5),
                instr(isa_pkg::ADDI, 7, 7, -1), instr(isa_pkg::HALT, 0, 0, 0)};
        run_program();
    endtask

    task automatic mem_test();
        logic [31:0] data;
        logic        err;
        prog = {load_imm(1, 8'h20), load_imm(2, $random(seed)),
                instr(isa_pkg::ADD, 3, 2, 1), instr(isa_pkg::ST, 2, 1, 0),
                instr(isa_pkg::ST, 3, 1, 1), instr(isa_pkg::LD, 5, 1, 1), // Load right behind store.
                instr(isa_pkg::ST, 1, 1, -1), instr(isa_pkg::LD, 6, 1, -1),
                instr(isa_pkg::LD, 7, 1, 0), instr(isa_pkg::ADD, 8, 5, 7),
                instr(isa_pkg::HALT, 0, 0, 0)};
        run_program();
        for (int k = 31; k <= 33; k++) begin
            apb_read(host_pkg::DMEM_BASE + 12'(4 * k), data, err);
            compare_word(data[15:0], model_dmem[k], $sformatf("dmem[%0d]", k));
            compare_word(data[31:16], '0, $sformatf("upper half of dmem[%0d]", k));
        end
    endtask

    task automatic branch_test();
        prog = {load_imm(1, 0), load_imm(2, 10),
                instr(isa_pkg::ADDI, 1, 1, 1), instr(isa_pkg::BNE, 1, 2, -2), // Count to ten.
                instr(isa_pkg::BEQ, 1, 0, 3), load_imm(3, 8'h33),
                instr(isa_pkg::BEQ, 1, 2, 2), load_imm(4, 8'hee), load_imm(5, 8'hee),
                load_imm(6, 8'h66), instr(isa_pkg::HALT, 0, 0, 0)};
        run_program();
    endtask

    task automatic halt_test();
        logic [31:0] status;
        logic        err;
        prog = {load_imm(1, 8'h11), load_imm(2, 8'h22), instr(isa_pkg::ADD, 3, 1, 2),
                instr(isa_pkg::HALT, 0, 0, 0), load_imm(4, 8'hab),
                instr(isa_pkg::ADD, 1, 1, 1), instr(isa_pkg::HALT, 0, 0, 0)};
        run_program();
        repeat (5) @(posedge clock);
        check_halt_status("status some cycles later");
        start_run();
        // This read lands as the first instruction reaches execute, with fetch at 2.
        apb_read(host_pkg::STATUS_ADDR, status, err);
        compare_status(status[host_pkg::STATUS_RUN_BIT], status[host_pkg::STATUS_HALT_BIT],
                       status[host_pkg::STATUS_PC_LSB +: 16], 1'b1, 1'b0, 16'd2,
                       "status early in the second run");
        wait_halt();
        check_registers();
        check_halt_status("status after the second run");
    endtask

    task automatic error_test();
        logic [31:0] data;
        logic        err;
        prog = {load_imm(1, 0), load_imm(2, 20), instr(isa_pkg::ADDI, 1, 1, 1),
                instr(isa_pkg::BNE, 1, 2, -2), load_imm(3, 8'h5a),
                instr(isa_pkg::HALT, 0, 0, 0)};
        load_program();
        run_model();
        start_run();
        apb_write(host_pkg::IMEM_BASE + 12'd16, 32'(load_imm(3, 8'hee)), err);
        compare_error(err, 1'b1, "IMEM write while running");
        wait_halt();
        check_registers();
        check_halt_status("status after HALT");
        apb_read(12'h008, data, err);
        compare_error(err, 1'b1, "unmapped read");
        apb_write(host_pkg::REG_BASE + 12'd4, 32'h1234, err);
        compare_error(err, 1'b1, "write to the REG window");
    endtask

//--- tests/pipe16_tb.sv
`default_nettype none

module pipe16_tb;

    localparam int PERIOD     = 4;
    localparam int IMEM_DEPTH = 256;
    localparam int DMEM_DEPTH = 256;
    localparam int POLL_LIMIT = 100;
    localparam int APB_CYCLES = 3; // Setup, access and one idle cycle.
    localparam int RUNS       = 7;
    // Each run may spend all its polls; doubled to cover program loads and readback.
    localparam int WATCHDOG_CYCLES = 10 + 2 * RUNS * POLL_LIMIT * APB_CYCLES;

    logic                            clock;
    logic                            rst;
    logic                            psel;
    logic                            penable;
    logic                            pwrite;
    logic [host_pkg::ADDR_WIDTH-1:0] paddr;
    logic [host_pkg::DATA_WIDTH-1:0] pwdata;
    wire  [host_pkg::DATA_WIDTH-1:0] prdata;
    wire                             pready;
    wire                             pslverr;

    isa_pkg::word_t prog[$];
    isa_pkg::word_t model_regs [16];
    isa_pkg::word_t model_dmem [DMEM_DEPTH];
    isa_pkg::word_t model_halt_pc;
    int             seed;
    int             checks;
    int             errors;
    int             test_errors;

    pipe16_top #(
        .IMEM_DEPTH(IMEM_DEPTH),
        .DMEM_DEPTH(DMEM_DEPTH)
    ) pipe16_top_i (
        .clock, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr
    );

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("Watchdog expired after %0d cycles and the run did not finish.",
                 WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    task automatic report_mismatch(input string msg);
        $display("Fail at time %0t: %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    task automatic compare_word(input isa_pkg::word_t got, input isa_pkg::word_t exp,
                                input string what);
        checks++;
        if (got !== exp) begin
            report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
        end
    endtask

    task automatic compare_status(input logic run, input logic halt, input isa_pkg::word_t pc,
                                  input logic run_exp, input logic halt_exp,
                                  input isa_pkg::word_t pc_exp, input string what);
        checks++;
        if (run !== run_exp || halt !== halt_exp || pc !== pc_exp) begin
            report_mismatch($sformatf("%s: running %b halted %b pc %h, expected %b %b %h",
                                      what, run, halt, pc, run_exp, halt_exp, pc_exp));
        end
    endtask

    task automatic compare_error(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            report_mismatch($sformatf("%s: pslverr is %b, expected %b", what, got, exp));
        end
    endtask

    task automatic apb_transfer(input logic write, input logic [11:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        @(negedge clock);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clock);
        penable = 1'b1;
        #(PERIOD / 4); // Still before the completing edge.
        rdata = prdata;
        err   = pslverr;
        if (pready !== 1'b1) begin
            report_mismatch("pready is low in an access phase");
        end
        @(negedge clock);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] unused;
        apb_transfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic err);
        apb_transfer(1'b0, addr, '0, data, err);
    endtask

    task automatic report_test(input string name);
        $display("%-20s %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    `include "pipe16_tests.svh"

    initial begin
        seed        = 91;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        rst         = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        foreach (model_regs[i]) begin
            model_regs[i] = '0;
        end
        repeat (10) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;
        alu_test();
        report_test("alu program");
        chain_test();
        report_test("dependences");
        mem_test();
        report_test("load and store");
        branch_test();
        report_test("branches");
        halt_test();
        report_test("halt and status");
        error_test();
        report_test("host errors");
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
